// ==== video_pkg.sv ====
`default_nettype none

package video_pkg;

    ////////////////////////////////////////////////////////////
    // Default display timing, small enough for short simulations
    ////////////////////////////////////////////////////////////

    localparam int DEF_H_ACTIVE = 16;
    localparam int DEF_H_FRONT  = 2;
    localparam int DEF_H_SYNC   = 3;
    localparam int DEF_H_BACK   = 3;

    localparam int DEF_V_ACTIVE = 12;
    localparam int DEF_V_FRONT  = 1;
    localparam int DEF_V_SYNC   = 2;
    localparam int DEF_V_BACK   = 1;

    // 4 bits per channel, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // Horizontal phases of one scan line
    typedef enum logic [1:0] {
        scan_active = 2'd0,
        scan_front  = 2'd1,
        scan_sync   = 2'd2,
        scan_back   = 2'd3
    } scan_state_t;

endpackage

`default_nettype wire

// ==== draw_pkg.sv ====
`default_nettype none

package draw_pkg;

    ////////////////////////////////////////////////////////////
    // Drawing commands and host register map
    ////////////////////////////////////////////////////////////

    // Opcode held in CTRL bit 0
    typedef enum logic {
        op_clear  = 1'b0,
        op_square = 1'b1
    } draw_op_t;

    // Word addresses on the Wishbone port
    typedef enum logic [2:0] {
        reg_ctrl   = 3'd0,
        reg_pos    = 3'd1,
        reg_fg     = 3'd2,
        reg_bg     = 3'd3,
        reg_status = 3'd4
    } wb_reg_t;

    // Drawing engine FSM
    typedef enum logic {
        idle   = 1'b0,
        render = 1'b1
    } draw_state_t;

    // Edge length of the filled square in pixels
    localparam int SQUARE_SIZE = 4;

endpackage

`default_nettype wire

// ==== wb_draw_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_draw_regs import video_pkg::*, draw_pkg::*; (
    input  logic        clk_system,
    input  logic        rstn_system,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        draw_start,
    output draw_op_t    draw_op,
    output logic [3:0]  pos_x,
    output logic [3:0]  pos_y,
    output rgb_t        fg,
    output rgb_t        bg,
    input  logic        frame_done,
    input  logic        swap_done,
    input  logic        front_sel
);
    wb_reg_t    reg_sel;
    draw_op_t   op_q;
    logic       wr_acc;
    logic       ctrl_wr;
    logic       drawing;
    logic       pending;
    logic       busy;
    logic [7:0] swap_cnt;

    assign reg_sel = wb_reg_t'(wb_adr);
    assign wr_acc  = wb_ack && wb_cyc && wb_stb && wb_we;
    assign ctrl_wr = wr_acc && (reg_sel == reg_ctrl);
    assign busy    = drawing || pending;

    // GO only launches from idle
    assign draw_start = ctrl_wr && wb_dat_w[1] && !busy;

    // Opcode written together with GO has to reach the engine in the same cycle
    assign draw_op = ctrl_wr ? draw_op_t'(wb_dat_w[0]) : op_q;

    // Single wait cycle, ack registered
    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_cyc && wb_stb && !wb_ack;
        end
    end

    // Command registers
    always_ff @(posedge clk_system) begin
        if (wr_acc) begin
            case (reg_sel)
                reg_ctrl: op_q <= draw_op_t'(wb_dat_w[0]);
                reg_pos: begin
                    pos_x <= wb_dat_w[3:0];
                    pos_y <= wb_dat_w[11:8];
                end
                reg_fg:   fg <= rgb_t'(wb_dat_w[11:0]);
                reg_bg:   bg <= rgb_t'(wb_dat_w[11:0]);
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Busy tracking: rendering, then waiting for the swap
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            drawing  <= 1'b0;
            pending  <= 1'b0;
            swap_cnt <= '0;
        end else begin
            if (draw_start) begin
                drawing <= 1'b1;
            end else if (frame_done) begin
                drawing <= 1'b0;
            end
            if (frame_done) begin
                pending <= 1'b1;
            end else if (swap_done) begin
                pending <= 1'b0;
            end
            if (swap_done) begin
                swap_cnt <= swap_cnt + 8'd1;
            end
        end
    end

    // Read data, valid while ack is high since the address is held
    always_comb begin
        wb_dat_r = '0;
        case (reg_sel)
            reg_ctrl: wb_dat_r[0] = op_q;
            reg_pos: begin
                wb_dat_r[3:0]  = pos_x;
                wb_dat_r[11:8] = pos_y;
            end
            reg_fg: wb_dat_r[11:0] = fg;
            reg_bg: wb_dat_r[11:0] = bg;
            reg_status: begin
                wb_dat_r[0]    = busy;
                wb_dat_r[1]    = front_sel;
                wb_dat_r[15:8] = swap_cnt;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== draw_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module draw_engine import video_pkg::*, draw_pkg::*; #(
    parameter int  H_ACTIVE = DEF_H_ACTIVE,
    parameter int  V_ACTIVE = DEF_V_ACTIVE,
    localparam int ADDR_W   = $clog2(H_ACTIVE * V_ACTIVE)
) (
    input  logic              clk_system,
    input  logic              rstn_system,
    input  logic              draw_start,
    input  draw_op_t          draw_op,
    input  logic [3:0]        pos_x,
    input  logic [3:0]        pos_y,
    input  rgb_t              fg,
    input  rgb_t              bg,
    output logic              wr_en,
    output logic [ADDR_W-1:0] wr_addr,
    output rgb_t              wr_data,
    output logic              frame_done
);
    localparam int X_W = $clog2(H_ACTIVE);
    localparam int Y_W = $clog2(V_ACTIVE);

    draw_state_t    state;
    logic [X_W-1:0] x_cnt;
    logic [Y_W-1:0] y_cnt;
    logic           last_pix;
    logic           in_square;

    // Command as latched at start
    draw_op_t   op_q;
    logic [3:0] px_q;
    logic [3:0] py_q;
    rgb_t       fg_q;
    rgb_t       bg_q;

    always_ff @(posedge clk_system) begin
        if (state == idle && draw_start) begin
            op_q <= draw_op;
            px_q <= pos_x;
            py_q <= pos_y;
            fg_q <= fg;
            bg_q <= bg;
        end
    end

    // Integer compare, so the square clips at the frame edge by itself
    assign in_square = (int'(x_cnt) >= int'(px_q))
                    && (int'(x_cnt) < int'(px_q) + SQUARE_SIZE)
                    && (int'(y_cnt) >= int'(py_q))
                    && (int'(y_cnt) < int'(py_q) + SQUARE_SIZE);

    assign last_pix = (wr_addr == ADDR_W'(H_ACTIVE * V_ACTIVE - 1));
    assign wr_en    = (state == render);
    assign wr_data  = (op_q == op_square && in_square) ? fg_q : bg_q;

    ////////////////////////////////////////////////////////////
    // Raster walk, one pixel per cycle
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            state      <= idle;
            x_cnt      <= '0;
            y_cnt      <= '0;
            wr_addr    <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                idle: begin
                    if (draw_start) begin
                        state   <= render;
                        x_cnt   <= '0;
                        y_cnt   <= '0;
                        wr_addr <= '0;
                    end
                end
                render: begin
                    wr_addr <= wr_addr + 1'b1;
                    if (x_cnt == X_W'(H_ACTIVE - 1)) begin
                        x_cnt <= '0;
                        y_cnt <= y_cnt + 1'b1;
                    end else begin
                        x_cnt <= x_cnt + 1'b1;
                    end
                    // Done pulse lands one cycle after the last write
                    if (last_pix) begin
                        state      <= idle;
                        frame_done <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== frame_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_store import video_pkg::*; #(
    parameter int  H_ACTIVE = DEF_H_ACTIVE,
    parameter int  V_ACTIVE = DEF_V_ACTIVE,
    localparam int DEPTH    = H_ACTIVE * V_ACTIVE,
    localparam int ADDR_W   = $clog2(DEPTH)
) (
    input  logic              clk_system,
    input  logic              rstn_system,
    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  rgb_t              wr_data,
    input  logic [ADDR_W-1:0] rd_addr,
    input  logic              frame_done,
    input  logic              vsync_start,
    output rgb_t              rd_data,
    output logic              front_sel,
    output logic              swap_done
);
    // Buffer index 0 or 1, front_sel names the one on screen
    rgb_t mem [2][DEPTH];

    logic back_sel;
    logic swap_pending;

    assign back_sel = ~front_sel;

    ////////////////////////////////////////////////////////////
    // Pixel memories
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_system) begin
        if (wr_en) begin
            mem[back_sel][wr_addr] <= wr_data;
        end
        rd_data <= mem[front_sel][rd_addr];
    end

    ////////////////////////////////////////////////////////////
    // Swap only at the start of vertical sync
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            front_sel    <= 1'b0;
            swap_pending <= 1'b0;
            swap_done    <= 1'b0;
        end else begin
            swap_done <= 1'b0;
            if (frame_done) begin
                swap_pending <= 1'b1;
            end
            if (vsync_start && swap_pending) begin
                front_sel    <= ~front_sel;
                swap_pending <= 1'b0;
                swap_done    <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== scan_out.sv ====
`timescale 1ns/100ps
`default_nettype none

module scan_out import video_pkg::*; #(
    parameter int  H_ACTIVE = DEF_H_ACTIVE,
    parameter int  H_FRONT  = DEF_H_FRONT,
    parameter int  H_SYNC   = DEF_H_SYNC,
    parameter int  H_BACK   = DEF_H_BACK,
    parameter int  V_ACTIVE = DEF_V_ACTIVE,
    parameter int  V_FRONT  = DEF_V_FRONT,
    parameter int  V_SYNC   = DEF_V_SYNC,
    parameter int  V_BACK   = DEF_V_BACK,
    localparam int ADDR_W   = $clog2(H_ACTIVE * V_ACTIVE)
) (
    input  logic              clk_system,
    input  logic              rstn_system,
    input  rgb_t              rd_data,
    output logic [ADDR_W-1:0] rd_addr,
    output logic              vsync_start,
    output logic              vga_hsync,
    output logic              vga_vsync,
    output logic              vga_de,
    output rgb_t              vga_rgb
);
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HC_W    = $clog2(H_TOTAL);
    localparam int VC_W    = $clog2(V_TOTAL);
    localparam int VS_FIRST = V_ACTIVE + V_FRONT;

    scan_state_t     state;
    logic [HC_W-1:0] h_cnt;
    logic [HC_W-1:0] phase_last;
    logic [VC_W-1:0] v_cnt;
    logic            active;
    logic            hsync_n;
    logic            vsync_n;
    logic            de_d;
    logic            hs_d;
    logic            vs_d;

    always_comb begin
        case (state)
            scan_active: phase_last = HC_W'(H_ACTIVE - 1);
            scan_front:  phase_last = HC_W'(H_FRONT - 1);
            scan_sync:   phase_last = HC_W'(H_SYNC - 1);
            default:     phase_last = HC_W'(H_BACK - 1);
        endcase
    end

    // h_cnt counts within the current phase, v_cnt counts whole lines
    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            state <= scan_active;
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == phase_last) begin
            h_cnt <= '0;
            case (state)
                scan_active: state <= scan_front;
                scan_front:  state <= scan_sync;
                scan_sync:   state <= scan_back;
                default: begin
                    state <= scan_active;
                    v_cnt <= (v_cnt == VC_W'(V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
                end
            endcase
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Address, sync levels and the vsync edge
    ////////////////////////////////////////////////////////////

    assign active  = (state == scan_active) && (int'(v_cnt) < V_ACTIVE);
    assign rd_addr = active ? ADDR_W'(int'(v_cnt) * H_ACTIVE + int'(h_cnt)) : '0;

    assign hsync_n = (state != scan_sync);
    assign vsync_n = !((int'(v_cnt) >= VS_FIRST) && (int'(v_cnt) < VS_FIRST + V_SYNC));

    // First cycle of the first sync line
    assign vsync_start = (v_cnt == VC_W'(VS_FIRST)) && (state == scan_active)
                      && (h_cnt == '0);

    // Two stages to line up with the registered memory read
    always_ff @(posedge clk_system or negedge rstn_system) begin
        if (!rstn_system) begin
            de_d      <= 1'b0;
            hs_d      <= 1'b1;
            vs_d      <= 1'b1;
            vga_de    <= 1'b0;
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_rgb   <= '0;
        end else begin
            de_d      <= active;
            hs_d      <= hsync_n;
            vs_d      <= vsync_n;
            vga_de    <= de_d;
            vga_hsync <= hs_d;
            vga_vsync <= vs_d;
            vga_rgb   <= de_d ? rd_data : '0;
        end
    end

endmodule

`default_nettype wire

// ==== gfx_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module gfx_top import video_pkg::*, draw_pkg::*; #(
    parameter int H_ACTIVE = DEF_H_ACTIVE,
    parameter int H_FRONT  = DEF_H_FRONT,
    parameter int H_SYNC   = DEF_H_SYNC,
    parameter int H_BACK   = DEF_H_BACK,
    parameter int V_ACTIVE = DEF_V_ACTIVE,
    parameter int V_FRONT  = DEF_V_FRONT,
    parameter int V_SYNC   = DEF_V_SYNC,
    parameter int V_BACK   = DEF_V_BACK
) (
    input  logic        clk_system,
    input  logic        rstn_system,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        vga_hsync,
    output logic        vga_vsync,
    output logic        vga_de,
    output rgb_t        vga_rgb
);
    localparam int ADDR_W = $clog2(H_ACTIVE * V_ACTIVE);

    // Command path
    logic       draw_start;
    draw_op_t   draw_op;
    logic [3:0] pos_x;
    logic [3:0] pos_y;
    rgb_t       fg;
    rgb_t       bg;
    logic       frame_done;

    // Buffer path
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    rgb_t              wr_data;
    logic [ADDR_W-1:0] rd_addr;
    rgb_t              rd_data;
    logic              vsync_start;
    logic              front_sel;
    logic              swap_done;

    ////////////////////////////////////////////////////////////
    // Stages
    ////////////////////////////////////////////////////////////

    wb_draw_regs u_regs (
        .clk_system  (clk_system),
        .rstn_system (rstn_system),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .draw_start  (draw_start),
        .draw_op     (draw_op),
        .pos_x       (pos_x),
        .pos_y       (pos_y),
        .fg          (fg),
        .bg          (bg),
        .frame_done  (frame_done),
        .swap_done   (swap_done),
        .front_sel   (front_sel)
    );

    draw_engine #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) u_engine (
        .clk_system  (clk_system),
        .rstn_system (rstn_system),
        .draw_start  (draw_start),
        .draw_op     (draw_op),
        .pos_x       (pos_x),
        .pos_y       (pos_y),
        .fg          (fg),
        .bg          (bg),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .frame_done  (frame_done)
    );

    frame_store #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) u_store (
        .clk_system  (clk_system),
        .rstn_system (rstn_system),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .rd_addr     (rd_addr),
        .frame_done  (frame_done),
        .vsync_start (vsync_start),
        .rd_data     (rd_data),
        .front_sel   (front_sel),
        .swap_done   (swap_done)
    );

    scan_out #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) u_scan (
        .clk_system  (clk_system),
        .rstn_system (rstn_system),
        .rd_data     (rd_data),
        .rd_addr     (rd_addr),
        .vsync_start (vsync_start),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_de      (vga_de),
        .vga_rgb     (vga_rgb)
    );

endmodule

`default_nettype wire

// ==== gfx_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module gfx_sva import video_pkg::*; (
    input logic clk_system,
    input logic rstn_system,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic vsync_start,
    input logic front_sel,
    input logic vga_de,
    input rgb_t vga_rgb
);

    // Failed assertions so far
    int fail_count = 0;

    // Registered ack lasts one cycle
    a_ack_one_cycle: assert property (
        @(posedge clk_system) disable iff (!rstn_system) wb_ack |=> !wb_ack
    ) else begin
        fail_count++;
        $error("wb_ack high for two cycles in a row");
    end

    a_ack_needs_req: assert property (
        @(posedge clk_system) disable iff (!rstn_system) wb_ack |-> (wb_cyc && wb_stb)
    ) else begin
        fail_count++;
        $error("wb_ack high without cyc and stb");
    end

    // Buffer swap only on the vsync edge
    a_swap_at_vsync: assert property (
        @(posedge clk_system) disable iff (!rstn_system)
            $changed(front_sel) |-> $past(vsync_start)
    ) else begin
        fail_count++;
        $error("front_sel changed away from vsync_start");
    end

    a_blank_colour: assert property (
        @(posedge clk_system) disable iff (!rstn_system) !vga_de |-> (vga_rgb == '0)
    ) else begin
        fail_count++;
        $error("vga_rgb not zero outside active video");
    end

endmodule

bind gfx_top gfx_sva u_sva (
    .clk_system  (clk_system),
    .rstn_system (rstn_system),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_ack      (wb_ack),
    .vsync_start (vsync_start),
    .front_sel   (front_sel),
    .vga_de      (vga_de),
    .vga_rgb     (vga_rgb)
);

`default_nettype wire

// ==== gfx_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module gfx_tb import video_pkg::*, draw_pkg::*; ();

    localparam int H_ACTIVE     = DEF_H_ACTIVE;
    localparam int V_ACTIVE     = DEF_V_ACTIVE;
    localparam int H_SYNC       = DEF_H_SYNC;
    localparam int FRAME_CYCLES = (DEF_H_ACTIVE + DEF_H_FRONT + DEF_H_SYNC + DEF_H_BACK)
                                * (DEF_V_ACTIVE + DEF_V_FRONT + DEF_V_SYNC + DEF_V_BACK);
    localparam int BUS_LIMIT    = 16;
    localparam int SWAP_LIMIT   = 4 * FRAME_CYCLES;

    logic        clk_system;
    logic        rstn_system;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        vga_hsync;
    logic        vga_vsync;
    logic        vga_de;
    rgb_t        vga_rgb;

    // Command the next captured frame should show
    draw_op_t   exp_op;
    logic [3:0] exp_x;
    logic [3:0] exp_y;
    rgb_t       exp_fg;
    rgb_t       exp_bg;

    int          error_count   = 0;
    int          timeout_count = 0;
    logic        capture_req;

    // The last three corners clip at the right or bottom edge
    logic [3:0] corner_x [4] = '{4'd0, 4'd15, 4'd13, 4'd6};
    logic [3:0] corner_y [4] = '{4'd0, 4'd11, 4'd2, 4'd9};

    initial begin
        clk_system = 1'b0;
        forever #2 clk_system = ~clk_system;
    end

    gfx_top UUT (
        .clk_system  (clk_system),
        .rstn_system (rstn_system),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_de      (vga_de),
        .vga_rgb     (vga_rgb)
    );

    ////////////////////////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////////////////////////

    function automatic rgb_t expected_pixel(input int x, input int y, input draw_op_t op,
                                            input logic [3:0] px, input logic [3:0] py,
                                            input rgb_t fg, input rgb_t bg);
        logic hit;
        hit = (x >= int'(px)) && (x < int'(px) + SQUARE_SIZE)
           && (y >= int'(py)) && (y < int'(py) + SQUARE_SIZE);
        return (op == op_square && hit) ? fg : bg;
    endfunction

    task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        int sva_fails;
        sva_fails = UUT.u_sva.fail_count;
        $display("Check errors: %0d, assertion failures: %0d, timeouts: %0d",
                 error_count, sva_fails, timeout_count);
        if (error_count == 0 && sva_fails == 0 && timeout_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("Timeout while waiting for %s", what);
        finish_run();
    endtask

    ////////////////////////////////////////////////////////////
    // Wishbone master
    ////////////////////////////////////////////////////////////

    task automatic bus_cycle(input logic we, input wb_reg_t adr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int n;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        n = 0;
        do begin
            @(posedge clk_system);
            #1;
            n++;
        end while (!wb_ack && n < BUS_LIMIT);
        if (!wb_ack) begin
            report_timeout("wb_ack");
        end
        rdata = wb_dat_r;
        // Write lands on the edge that closes the ack cycle
        @(posedge clk_system);
        #1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_dat_w = '0;
    endtask

    task automatic wb_write(input wb_reg_t adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input wb_reg_t adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'h0, data);
    endtask

    task automatic start_draw(input draw_op_t op, input logic [3:0] x, input logic [3:0] y,
                              input rgb_t fg, input rgb_t bg);
        wb_write(reg_pos, {20'h0, y, 4'h0, x});
        wb_write(reg_fg, {20'h0, fg});
        wb_write(reg_bg, {20'h0, bg});
        wb_write(reg_ctrl, {30'h0, 1'b1, op});
        exp_op = op;
        exp_x  = x;
        exp_y  = y;
        exp_fg = fg;
        exp_bg = bg;
    endtask

    // Poll STATUS until the swap counter shows the target
    task automatic wait_swap_count(input logic [7:0] target);
        logic [31:0] word;
        int          n;
        n = 0;
        wb_read(reg_status, word);
        while (word[15:8] != target && n < SWAP_LIMIT) begin
            wb_read(reg_status, word);
            n++;
        end
        if (word[15:8] != target) begin
            report_timeout("the swap counter to advance");
        end
    endtask

    // Returns a couple of cycles after vsync_start
    task automatic wait_vsync_fall();
        logic vs_prev;
        int   n;
        n       = 0;
        vs_prev = vga_vsync;
        @(posedge clk_system);
        #1;
        while (!(vs_prev && !vga_vsync) && n < 2 * FRAME_CYCLES) begin
            vs_prev = vga_vsync;
            @(posedge clk_system);
            #1;
            n++;
        end
        if (!(vs_prev && !vga_vsync)) begin
            report_timeout("vsync before the second GO");
        end
    endtask

    task automatic frame_check();
        int n;
        capture_req = 1'b1;
        n = 0;
        while (capture_req && n < 3 * FRAME_CYCLES) begin
            @(posedge clk_system);
            #1;
            n++;
        end
        if (capture_req) begin
            report_timeout("the frame capture to finish");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Frame capture and compare process
    ////////////////////////////////////////////////////////////

    task automatic capture_frame();
        int   n;
        int   col;
        int   row;
        int   hs_len;
        logic vs_prev;
        logic ended;
        // Falling vsync opens the frame
        n = 0;
        @(negedge clk_system);
        vs_prev = vga_vsync;
        @(negedge clk_system);
        while (!(vs_prev && !vga_vsync) && n < 2 * FRAME_CYCLES) begin
            vs_prev = vga_vsync;
            @(negedge clk_system);
            n++;
        end
        if (!(vs_prev && !vga_vsync)) begin
            report_timeout("vsync before the frame capture");
        end
        col     = 0;
        row     = 0;
        hs_len  = 0;
        ended   = 1'b0;
        n       = 0;
        vs_prev = vga_vsync;
        while (!ended && n < 2 * FRAME_CYCLES) begin
            @(negedge clk_system);
            n++;
            if (vga_de) begin
                if (col < H_ACTIVE && row < V_ACTIVE) begin
                    check_rgb($sformatf("vga_rgb (%0d,%0d)", col, row), vga_rgb,
                              expected_pixel(col, row, exp_op, exp_x, exp_y, exp_fg, exp_bg));
                end
                col++;
            end else if (col != 0) begin
                check_count("vga_de pixels per line", 8'(col), 8'(H_ACTIVE));
                row++;
                col = 0;
            end
            if (!vga_hsync) begin
                hs_len++;
            end else if (hs_len != 0) begin
                check_count("vga_hsync pulse length", 8'(hs_len), 8'(H_SYNC));
                hs_len = 0;
            end
            if (vs_prev && !vga_vsync) begin
                ended = 1'b1;
            end
            vs_prev = vga_vsync;
        end
        if (!ended) begin
            report_timeout("the vsync that closes the frame");
        end
        check_count("vga_de lines per frame", 8'(row), 8'(V_ACTIVE));
    endtask

    initial begin
        capture_req = 1'b0;
        forever begin
            @(posedge clk_system);
            if (capture_req) begin
                capture_frame();
                capture_req = 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] word;
        logic [7:0]  swaps;
        logic [3:0]  rx;
        logic [3:0]  ry;
        rgb_t        rfg;
        rgb_t        rbg;

        void'($urandom(32'h2238_c718));
        rstn_system = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        repeat (3) @(posedge clk_system);
        #1;
        rstn_system = 1'b1;

        // Idle outputs and STATUS after reset
        check_bit("vga_hsync", vga_hsync, 1'b1);
        check_bit("vga_vsync", vga_vsync, 1'b1);
        check_bit("vga_de", vga_de, 1'b0);
        wb_read(reg_status, word);
        check_bit("status busy", word[0], 1'b0);
        check_bit("status front", word[1], 1'b0);
        check_count("status swap count", word[15:8], 8'd0);

        // Clear to a random background
        rbg = rgb_t'(12'($urandom()));
        rfg = rgb_t'(12'($urandom()));
        start_draw(op_clear, 4'd0, 4'd0, rfg, rbg);
        swaps = 8'd1;
        wait_swap_count(swaps);
        frame_check();
        wb_read(reg_status, word);
        check_bit("status front", word[1], 1'b1);
        check_bit("status busy", word[0], 1'b0);

        // Squares at corner positions first and then at random ones
        for (int i = 0; i < 7; i++) begin
            if (i < 4) begin
                rx = corner_x[i];
                ry = corner_y[i];
            end else begin
                rx = 4'($urandom_range(15, 0));
                ry = 4'($urandom_range(11, 0));
            end
            rfg = rgb_t'(12'($urandom()));
            rbg = rgb_t'(12'($urandom()));
            if (rfg == rbg) begin
                rfg = ~rbg;
            end
            start_draw(op_square, rx, ry, rfg, rbg);
            swaps++;
            wait_swap_count(swaps);
            frame_check();
        end

        // Second GO during a draw has to be dropped
        wait_vsync_fall();
        start_draw(op_square, 4'd5, 4'd4, rgb_t'(12'hf80), rgb_t'(12'h03c));
        wb_write(reg_ctrl, {30'h0, 1'b1, op_clear});
        // One pixel per cycle, so the frame is now done and waits for its swap
        repeat (H_ACTIVE * V_ACTIVE) @(posedge clk_system);
        #1;
        wb_read(reg_status, word);
        check_bit("status busy", word[0], 1'b1);
        check_count("status swap count", word[15:8], swaps);
        wb_write(reg_ctrl, {30'h0, 1'b1, op_clear});
        swaps++;
        wait_swap_count(swaps);
        frame_check();
        wb_read(reg_status, word);
        check_count("status swap count", word[15:8], swaps);
        check_bit("status busy", word[0], 1'b0);

        // Frame keeps the command latched before these writes
        start_draw(op_square, 4'd2, 4'd7, rgb_t'(12'h0f0), rgb_t'(12'h111));
        wb_write(reg_pos, 32'h0000_030a);
        wb_write(reg_fg, 32'h0000_0abc);
        wb_write(reg_bg, 32'h0000_0456);
        wb_read(reg_status, word);
        check_bit("status busy", word[0], 1'b1);
        wb_read(reg_pos, word);
        check_word("pos readback", word, 32'h0000_030a);
        wb_read(reg_fg, word);
        check_word("fg readback", word, 32'h0000_0abc);
        wb_read(reg_bg, word);
        check_word("bg readback", word, 32'h0000_0456);
        swaps++;
        wait_swap_count(swaps);
        frame_check();

        // Stored values take effect on the next GO
        wb_write(reg_ctrl, {30'h0, 1'b1, op_square});
        exp_x  = 4'ha;
        exp_y  = 4'h3;
        exp_fg = rgb_t'(12'habc);
        exp_bg = rgb_t'(12'h456);
        swaps++;
        wait_swap_count(swaps);
        frame_check();

        finish_run();
    end

endmodule

`default_nettype wire

// ==== compile.f ====
video_pkg.sv
draw_pkg.sv
wb_draw_regs.sv
draw_engine.sv
frame_store.sv
scan_out.sv
gfx_top.sv
gfx_sva.sv
gfx_tb.sv

// ==== Bender.yml ====
package:
  name: gfx_raster

sources:
  # Packages
  - files:
      - video_pkg.sv
      - draw_pkg.sv
  # RTL
  - files:
      - wb_draw_regs.sv
      - draw_engine.sv
      - frame_store.sv
      - scan_out.sv
      - gfx_top.sv
  # Testbench
  - target: test
    files:
      - gfx_sva.sv
      - gfx_tb.sv
